/* Makefile */
# Verilator flow for the register file and its testbench
VERILATOR ?= verilator
TOP       ?= vic_registers_tb
RTL_TOP   ?= vic_registers
FILELIST  ?= vic_registers.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation passed

RTL_SRCS = vic_regs_pkg.sv vic_bus_decode.sv vic_sprite_slot.sv \
           vic_control_regs.sv vic_read_mux.sv vic_registers.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk_dot4x,
    output logic rst
);

    initial begin
        clk_dot4x = 1'b0;
        forever begin
            #(period_ns / 2) clk_dot4x = ~clk_dot4x;
        end
    end

    // reset is released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk_dot4x);
        rst <= 1'b0;
    end

endmodule

/* vic_bus_decode.sv */
`timescale 1ns/1ps

module vic_bus_decode
    import vic_regs_pkg::*;
(
    input  logic       clk_dot4x,
    input  logic       rst,
    input  logic       clk_phi,
    input  logic       ras,
    input  logic       aec,
    input  logic       ce,
    input  logic       rw,
    input  logic [5:0] adi,
    input  logic [7:0] dbi,
    input  logic       phi_phase_start_dav,
    input  logic       phi_phase_start_dav_plus_1,
    output bus_req_t   bus_req
);

    bus_state_e state;
    logic [5:0] addr_q;
    logic       latch_en;
    logic       cpu_cycle;
    logic       access_open;

    // address is valid once ras drops in the high phase
    assign latch_en    = (state == idle) && !ras && clk_phi && !phi_phase_start_dav_plus_1;
    assign cpu_cycle   = aec && !ce;
    assign access_open = (state == latched) || (state == read_served);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            state <= idle;
        end else if (phi_phase_start_dav_plus_1) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (latch_en) begin
                        state <= latched;
                    end
                end
                latched: begin
                    // only one read per access
                    if (bus_req.rd) begin
                        state <= read_served;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (latch_en) begin
            addr_q <= adi;
        end
    end

    // combinational so every consumer acts on the same edge
    always_comb begin
        bus_req.rd         = (state == latched) && cpu_cycle && rw;
        bus_req.wr         = access_open && cpu_cycle && !rw && phi_phase_start_dav;
        bus_req.rd_dav     = access_open && cpu_cycle && rw && phi_phase_start_dav;
        bus_req.end_access = phi_phase_start_dav_plus_1;
        // clears land at dav+1 of the video phase
        bus_req.clr_pulses = phi_phase_start_dav_plus_1 && !clk_phi;
        bus_req.addr       = reg_addr_e'(addr_q);
        bus_req.data       = dbi;
    end

endmodule

/* vic_control_regs.sv */
`timescale 1ns/1ps

module vic_control_regs
    import vic_regs_pkg::*;
(
    input  logic          clk_dot4x,
    input  logic          rst,
    input  bus_req_t      bus_req,
    output screen_ctrl_t  screen_ctrl,
    output mem_setup_t    mem_setup,
    output colors_t       colors,
    output sprite_masks_t masks,
    output logic [8:0]    raster_irq_compare,
    output irq_bits_t     irq_en,
    output irq_bits_t     irq_clr,
    output logic          m2m_clr,
    output logic          m2d_clr,
    output logic          handle_sprite_crunch
);

    // plain data fields
    always_ff @(posedge clk_dot4x) begin
        if (bus_req.wr) begin
            case (bus_req.addr)
                reg_screen_ctrl_1: begin
                    screen_ctrl.yscroll   <= bus_req.data[2:0];
                    screen_ctrl.rsel      <= bus_req.data[3];
                    screen_ctrl.den       <= bus_req.data[4];
                    screen_ctrl.bmm       <= bus_req.data[5];
                    screen_ctrl.ecm       <= bus_req.data[6];
                    raster_irq_compare[8] <= bus_req.data[7];
                end
                reg_raster: begin
                    raster_irq_compare[7:0] <= bus_req.data;
                end
                reg_sprite_en: begin
                    masks.en <= bus_req.data;
                end
                reg_screen_ctrl_2: begin
                    screen_ctrl.xscroll <= bus_req.data[2:0];
                    screen_ctrl.csel    <= bus_req.data[3];
                    screen_ctrl.mcm     <= bus_req.data[4];
                    screen_ctrl.res     <= bus_req.data[5];
                end
                reg_sprite_ye: begin
                    masks.ye <= bus_req.data;
                end
                reg_mem_setup: begin
                    // bit 0 is unused and reads back as one
                    mem_setup.cb <= bus_req.data[3:1];
                    mem_setup.vm <= bus_req.data[7:4];
                end
                reg_sprite_pri: begin
                    masks.pri <= bus_req.data;
                end
                reg_sprite_mmc: begin
                    masks.mmc <= bus_req.data;
                end
                reg_sprite_xe: begin
                    masks.xe <= bus_req.data;
                end
                reg_border_color: colors.ec <= bus_req.data[3:0];
                reg_bg_color_0: colors.b0c <= bus_req.data[3:0];
                reg_bg_color_1: colors.b1c <= bus_req.data[3:0];
                reg_bg_color_2: colors.b2c <= bus_req.data[3:0];
                reg_bg_color_3: colors.b3c <= bus_req.data[3:0];
                reg_sprite_mc_0: colors.mc0 <= bus_req.data[3:0];
                reg_sprite_mc_1: colors.mc1 <= bus_req.data[3:0];
                default: begin
                end
            endcase
        end
    end

    // enables and the one-access pulses
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irq_en               <= '0;
            irq_clr              <= '0;
            m2m_clr              <= 1'b0;
            m2d_clr              <= 1'b0;
            handle_sprite_crunch <= 1'b0;
        end else begin
            // drop clears once the interrupt logic has seen them
            if (bus_req.clr_pulses) begin
                irq_clr <= '0;
                m2m_clr <= 1'b0;
                m2d_clr <= 1'b0;
            end
            if (bus_req.end_access) begin
                handle_sprite_crunch <= 1'b0;
            end

            if (bus_req.wr) begin
                case (bus_req.addr)
                    reg_sprite_ye: handle_sprite_crunch <= 1'b1;
                    // writing a one acknowledges that interrupt source
                    reg_irq_status: irq_clr <= irq_bits_t'(bus_req.data[3:0]);
                    reg_irq_ctrl: irq_en <= irq_bits_t'(bus_req.data[3:0]);
                    default: begin
                    end
                endcase
            end

            // collision registers clear on read, but only at dav
            if (bus_req.rd_dav) begin
                if (bus_req.addr == reg_sprite_m2m) begin
                    m2m_clr <= 1'b1;
                end
                if (bus_req.addr == reg_sprite_m2d) begin
                    m2d_clr <= 1'b1;
                end
            end
        end
    end

endmodule

/* vic_read_mux.sv */
`timescale 1ns/1ps

module vic_read_mux
    import vic_regs_pkg::*;
(
    input  logic          clk_dot4x,
    input  bus_req_t      bus_req,
    input  sprite_t       sprites [num_sprites],
    input  screen_ctrl_t  screen_ctrl,
    input  mem_setup_t    mem_setup,
    input  colors_t       colors,
    input  sprite_masks_t masks,
    input  irq_bits_t     irq_en,
    input  vic_status_t   status,
    output logic [7:0]    dbo
);

    logic [2:0] spr_idx;
    logic [2:0] col_idx;
    logic [7:0] x_msb;
    logic [7:0] rd_value;

    // bit 0 picks y within the interleaved x and y pairs
    assign spr_idx = bus_req.addr[3:1];
    assign col_idx = 3'(bus_req.addr - reg_sprite_color_0);

    always_comb begin
        for (int i = 0; i < num_sprites; i++) begin
            x_msb[i] = sprites[i].x[8];
        end
    end

    always_comb begin
        rd_value = 8'hff;
        case (bus_req.addr) inside
            [reg_sprite_x_0:reg_sprite_y_7]: begin
                if (bus_req.addr[0]) begin
                    rd_value = sprites[spr_idx].y;
                end else begin
                    rd_value = sprites[spr_idx].x[7:0];
                end
            end
            reg_sprite_x_msb: rd_value = x_msb;
            // top bit is the live raster line, not the compare value
            reg_screen_ctrl_1: begin
                rd_value = {status.raster_line[8], screen_ctrl.ecm, screen_ctrl.bmm,
                            screen_ctrl.den, screen_ctrl.rsel, screen_ctrl.yscroll};
            end
            reg_raster: rd_value = status.raster_line[7:0];
            reg_lpx: rd_value = status.lpx;
            reg_lpy: rd_value = status.lpy;
            reg_sprite_en: rd_value = masks.en;
            reg_screen_ctrl_2: begin
                rd_value = {2'b11, screen_ctrl.res, screen_ctrl.mcm,
                            screen_ctrl.csel, screen_ctrl.xscroll};
            end
            reg_sprite_ye: rd_value = masks.ye;
            reg_mem_setup: rd_value = {mem_setup.vm, mem_setup.cb, 1'b1};
            reg_irq_status: rd_value = {status.irq, 3'b111, status.irq_status};
            reg_irq_ctrl: rd_value = {4'hf, irq_en};
            reg_sprite_pri: rd_value = masks.pri;
            reg_sprite_mmc: rd_value = masks.mmc;
            reg_sprite_xe: rd_value = masks.xe;
            reg_sprite_m2m: rd_value = status.sprite_m2m;
            reg_sprite_m2d: rd_value = status.sprite_m2d;
            reg_border_color: rd_value = {4'hf, colors.ec};
            reg_bg_color_0: rd_value = {4'hf, colors.b0c};
            reg_bg_color_1: rd_value = {4'hf, colors.b1c};
            reg_bg_color_2: rd_value = {4'hf, colors.b2c};
            reg_bg_color_3: rd_value = {4'hf, colors.b3c};
            reg_sprite_mc_0: rd_value = {4'hf, colors.mc0};
            reg_sprite_mc_1: rd_value = {4'hf, colors.mc1};
            [reg_sprite_color_0:reg_sprite_color_7]: begin
                rd_value = {4'hf, sprites[col_idx].col};
            end
            // unmapped top of the map floats high
            [6'h2f:reg_last]: rd_value = 8'hff;
            default: rd_value = 8'hff;
        endcase
    end

    // dbo holds until the next read
    always_ff @(posedge clk_dot4x) begin
        if (bus_req.rd) begin
            dbo <= rd_value;
        end
    end

endmodule

/* vic_registers.f */
vic_regs_pkg.sv
vic_bus_decode.sv
vic_sprite_slot.sv
vic_control_regs.sv
vic_read_mux.sv
vic_registers.sv
tb_clock_gen.sv
vic_registers_assert.sv
vic_registers_tb.sv

/* vic_registers.sv */
`timescale 1ns/1ps

module vic_registers
    import vic_regs_pkg::*;
(
    input  logic          clk_dot4x,
    input  logic          rst,
    input  logic          clk_phi,
    input  logic          ras,
    input  logic          aec,
    input  logic          ce,
    input  logic          rw,
    input  logic [5:0]    adi,
    input  logic [7:0]    dbi,
    input  logic          phi_phase_start_dav,
    input  logic          phi_phase_start_dav_plus_1,
    input  vic_status_t   status,
    output logic [7:0]    dbo,
    output sprite_t       sprites [num_sprites],
    output screen_ctrl_t  screen_ctrl,
    output mem_setup_t    mem_setup,
    output colors_t       colors,
    output sprite_masks_t masks,
    output logic [8:0]    raster_irq_compare,
    output irq_bits_t     irq_en,
    output irq_bits_t     irq_clr,
    output logic          m2m_clr,
    output logic          m2d_clr,
    output logic          handle_sprite_crunch
);

    bus_req_t bus_req;

    vic_bus_decode u_decode (
        .clk_dot4x                  (clk_dot4x),
        .rst                        (rst),
        .clk_phi                    (clk_phi),
        .ras                        (ras),
        .aec                        (aec),
        .ce                         (ce),
        .rw                         (rw),
        .adi                        (adi),
        .dbi                        (dbi),
        .phi_phase_start_dav        (phi_phase_start_dav),
        .phi_phase_start_dav_plus_1 (phi_phase_start_dav_plus_1),
        .bus_req                    (bus_req)
    );

    // one slot per sprite, each decodes its own addresses
    for (genvar i = 0; i < num_sprites; i++) begin : g_sprite
        vic_sprite_slot #(
            .index (i)
        ) u_slot (
            .clk_dot4x (clk_dot4x),
            .bus_req   (bus_req),
            .sprite    (sprites[i])
        );
    end

    vic_control_regs u_control (
        .clk_dot4x            (clk_dot4x),
        .rst                  (rst),
        .bus_req              (bus_req),
        .screen_ctrl          (screen_ctrl),
        .mem_setup            (mem_setup),
        .colors               (colors),
        .masks                (masks),
        .raster_irq_compare   (raster_irq_compare),
        .irq_en               (irq_en),
        .irq_clr              (irq_clr),
        .m2m_clr              (m2m_clr),
        .m2d_clr              (m2d_clr),
        .handle_sprite_crunch (handle_sprite_crunch)
    );

    vic_read_mux u_read_mux (
        .clk_dot4x   (clk_dot4x),
        .bus_req     (bus_req),
        .sprites     (sprites),
        .screen_ctrl (screen_ctrl),
        .mem_setup   (mem_setup),
        .colors      (colors),
        .masks       (masks),
        .irq_en      (irq_en),
        .status      (status),
        .dbo         (dbo)
    );

endmodule

/* vic_registers_assert.sv */
`timescale 1ns/1ps

module vic_registers_assert
    import vic_regs_pkg::*;
(
    input logic       clk_dot4x,
    input logic       rst,
    input bus_req_t   bus_req,
    input irq_bits_t  irq_clr,
    input logic       m2m_clr,
    input logic       m2d_clr,
    input logic       handle_sprite_crunch,
    input logic [7:0] dbo
);

    int fail_count = 0;

    // clears last until dav+1 of the video phase
    clr_drop: assert property (@(posedge clk_dot4x) disable iff (rst)
        bus_req.clr_pulses |=> ((irq_clr == '0) && !m2m_clr && !m2d_clr))
    else begin
        fail_count++;
        $error("clear pulse still high one cycle after clr_pulses");
    end

    crunch_drop: assert property (@(posedge clk_dot4x) disable iff (rst)
        bus_req.end_access |=> !handle_sprite_crunch)
    else begin
        fail_count++;
        $error("handle_sprite_crunch still high one cycle after end_access");
    end

    // dbo is only loaded by a served read
    dbo_hold: assert property (@(posedge clk_dot4x) disable iff (rst)
        !$stable(dbo) |-> $past(bus_req.rd))
    else begin
        fail_count++;
        $error("dbo changed without a read one cycle before");
    end

endmodule

/* vic_registers_tb.sv */
`timescale 1ns/1ps

module vic_registers_tb
    import vic_regs_pkg::*;
();

    localparam int period_ns = 20;
    localparam int num_random = 200;
    // write pass, read sweep, random mix and one trailing idle period
    localparam int num_accesses = 47 + 64 + num_random + 1;
    localparam longint timeout_ns = longint'(num_accesses + 2) * 16 * period_ns * 2;

    logic          clk_dot4x;
    logic          rst;
    logic          clk_phi;
    logic          ras;
    logic          aec;
    logic          ce;
    logic          rw;
    logic [5:0]    adi;
    logic [7:0]    dbi;
    logic          phi_phase_start_dav;
    logic          phi_phase_start_dav_plus_1;
    vic_status_t   status;
    logic [7:0]    dbo;
    sprite_t       sprites [num_sprites];
    screen_ctrl_t  screen_ctrl;
    mem_setup_t    mem_setup;
    colors_t       colors;
    sprite_masks_t masks;
    logic [8:0]    raster_irq_compare;
    irq_bits_t     irq_en;
    irq_bits_t     irq_clr;
    logic          m2m_clr;
    logic          m2d_clr;
    logic          handle_sprite_crunch;

    logic [7:0] shadow [64];
    integer     seed;
    int         err_count;
    int         access_count;
    int         cur_cyc;
    logic       cur_active;
    logic       cur_write;
    logic [5:0] cur_addr;
    logic [7:0] cur_data;
    logic       outputs_valid;
    logic       dbo_known;
    logic       reset_checked;
    logic [7:0] last_dbo;
    logic [7:0] exp_byte;
    irq_bits_t  exp_clr;
    logic [2:0] exp_flags;

    tb_clock_gen #(.period_ns(period_ns), .reset_cycles(2)) clk_gen_i (
        .clk_dot4x (clk_dot4x),
        .rst       (rst)
    );

    vic_registers dut_i (
        .clk_dot4x                  (clk_dot4x),
        .rst                        (rst),
        .clk_phi                    (clk_phi),
        .ras                        (ras),
        .aec                        (aec),
        .ce                         (ce),
        .rw                         (rw),
        .adi                        (adi),
        .dbi                        (dbi),
        .phi_phase_start_dav        (phi_phase_start_dav),
        .phi_phase_start_dav_plus_1 (phi_phase_start_dav_plus_1),
        .status                     (status),
        .dbo                        (dbo),
        .sprites                    (sprites),
        .screen_ctrl                (screen_ctrl),
        .mem_setup                  (mem_setup),
        .colors                     (colors),
        .masks                      (masks),
        .raster_irq_compare         (raster_irq_compare),
        .irq_en                     (irq_en),
        .irq_clr                    (irq_clr),
        .m2m_clr                    (m2m_clr),
        .m2d_clr                    (m2d_clr),
        .handle_sprite_crunch       (handle_sprite_crunch)
    );

    bind vic_registers vic_registers_assert assert_i (
        .clk_dot4x            (clk_dot4x),
        .rst                  (rst),
        .bus_req              (bus_req),
        .irq_clr              (irq_clr),
        .m2m_clr              (m2m_clr),
        .m2d_clr              (m2d_clr),
        .handle_sprite_crunch (handle_sprite_crunch),
        .dbo                  (dbo)
    );

    // expected cpu read value from the register map rules
    function automatic logic [7:0] ref_read(input logic [5:0] addr, input vic_status_t st);
        logic [7:0] value;
        value = 8'hff;
        case (addr) inside
            [6'h00:6'h10], 6'h15, 6'h17, 6'h1b, 6'h1c, 6'h1d: value = shadow[addr];
            6'h11: value = {st.raster_line[8], shadow[addr][6:0]};
            6'h12: value = st.raster_line[7:0];
            6'h13: value = st.lpx;
            6'h14: value = st.lpy;
            6'h16: value = {2'b11, shadow[addr][5:0]};
            6'h18: value = {shadow[addr][7:1], 1'b1};
            6'h19: value = {st.irq, 3'b111, st.irq_status};
            6'h1a: value = {4'hf, shadow[addr][3:0]};
            6'h1e: value = st.sprite_m2m;
            6'h1f: value = st.sprite_m2d;
            // color registers keep only a palette index
            [6'h20:6'h2e]: value = {4'hf, shadow[addr][3:0]};
            default: value = 8'hff;
        endcase
        return value;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_count++;
        $display("ERR %0t %s got=%0h exp=%0h", $time, name, got, exp);
    endtask

    // decoded fields against the last written bytes
    task automatic check_decoded();
        sprite_t       exp_spr;
        screen_ctrl_t  exp_sc;
        mem_setup_t    exp_mem;
        colors_t       exp_col;
        sprite_masks_t exp_msk;
        for (int i = 0; i < num_sprites; i++) begin
            exp_spr.x   = {shadow[6'h10][i], shadow[2 * i]};
            exp_spr.y   = shadow[2 * i + 1];
            exp_spr.col = shadow[6'h27 + i][3:0];
            if (sprites[i] !== exp_spr) begin
                report_mismatch($sformatf("sprites[%0d]", i), 64'(sprites[i]), 64'(exp_spr));
            end
        end
        exp_sc = {shadow[6'h11][2:0], shadow[6'h11][3], shadow[6'h11][4], shadow[6'h11][5],
                  shadow[6'h11][6], shadow[6'h16][2:0], shadow[6'h16][3], shadow[6'h16][4],
                  shadow[6'h16][5]};
        exp_mem = {shadow[6'h18][3:1], shadow[6'h18][7:4]};
        exp_col = {shadow[6'h20][3:0], shadow[6'h21][3:0], shadow[6'h22][3:0],
                   shadow[6'h23][3:0], shadow[6'h24][3:0], shadow[6'h25][3:0],
                   shadow[6'h26][3:0]};
        exp_msk = {shadow[6'h15], shadow[6'h1d], shadow[6'h17], shadow[6'h1b], shadow[6'h1c]};
        if (screen_ctrl !== exp_sc) begin
            report_mismatch("screen_ctrl", 64'(screen_ctrl), 64'(exp_sc));
        end
        if (mem_setup !== exp_mem) begin
            report_mismatch("mem_setup", 64'(mem_setup), 64'(exp_mem));
        end
        if (colors !== exp_col) begin
            report_mismatch("colors", 64'(colors), 64'(exp_col));
        end
        if (masks !== exp_msk) begin
            report_mismatch("masks", 64'(masks), 64'(exp_msk));
        end
        if (raster_irq_compare !== {shadow[6'h11][7], shadow[6'h12]}) begin
            report_mismatch("raster_irq_compare", 64'(raster_irq_compare),
                            64'({shadow[6'h11][7], shadow[6'h12]}));
        end
        if (irq_en !== shadow[6'h1a][3:0]) begin
            report_mismatch("irq_en", 64'(irq_en), 64'(shadow[6'h1a][3:0]));
        end
    endtask

    // one phi period of 16 clocks with or without a cpu access
    task automatic run_period(input logic active, input logic write, input logic [5:0] addr,
                              input logic [7:0] data);
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        cur_active = active;
        cur_write = write;
        cur_addr = addr;
        cur_data = data;
        for (int c = 0; c < 16; c++) begin
            @(posedge clk_dot4x);
            cur_cyc = c;
            if (c == 0) begin
                status <= r[45:0];
            end
            clk_phi <= (c >= 8);
            ras <= !(active && c >= 9 && c <= 13);
            ce <= !(active && c >= 9 && c <= 14);
            // strobes come in both halves of phi
            phi_phase_start_dav <= (c == 5) || (c == 13);
            phi_phase_start_dav_plus_1 <= (c == 6) || (c == 14);
            if (c == 8) begin
                adi <= addr;
                rw <= !write;
                dbi <= data;
            end
        end
        if (active && write) begin
            shadow[addr] = data;
        end
        if (active) begin
            access_count++;
        end
    endtask

    // compare process samples half a cycle after the driving edge
    always @(negedge clk_dot4x) begin
        if (!rst && !reset_checked) begin
            reset_checked = 1'b1;
            if ({irq_clr, m2m_clr, m2d_clr, handle_sprite_crunch, irq_en} !== '0) begin
                report_mismatch("pulses and irq_en after reset",
                                64'({irq_clr, m2m_clr, m2d_clr, handle_sprite_crunch, irq_en}),
                                64'(0));
            end
        end
        if (cur_cyc == 12) begin
            if (cur_active && !cur_write) begin
                exp_byte = ref_read(cur_addr, status);
                if (dbo !== exp_byte) begin
                    report_mismatch($sformatf("dbo @%02h", cur_addr), 64'(dbo), 64'(exp_byte));
                end
                last_dbo = exp_byte;
                dbo_known = 1'b1;
            end else if (dbo_known && dbo !== last_dbo) begin
                report_mismatch("dbo hold", 64'(dbo), 64'(last_dbo));
            end
        end
        if (cur_cyc == 14) begin
            exp_clr = (cur_active && cur_write && cur_addr == 6'h19) ? cur_data[3:0] : 4'h0;
            exp_flags = {cur_active && cur_write && cur_addr == 6'h17,
                         cur_active && !cur_write && cur_addr == 6'h1e,
                         cur_active && !cur_write && cur_addr == 6'h1f};
            if (irq_clr !== exp_clr) begin
                report_mismatch("irq_clr", 64'(irq_clr), 64'(exp_clr));
            end
            if ({handle_sprite_crunch, m2m_clr, m2d_clr} !== exp_flags) begin
                report_mismatch("crunch/m2m_clr/m2d_clr",
                                64'({handle_sprite_crunch, m2m_clr, m2d_clr}), 64'(exp_flags));
            end
        end
        if (cur_cyc == 8) begin
            if ({irq_clr, m2m_clr, m2d_clr, handle_sprite_crunch} !== '0) begin
                report_mismatch("pulses before access",
                                64'({irq_clr, m2m_clr, m2d_clr, handle_sprite_crunch}), 64'(0));
            end
            if (outputs_valid) begin
                check_decoded();
            end
        end
    end

    initial begin
        logic [31:0] r;
        seed = 58;
        err_count = 0;
        access_count = 0;
        cur_cyc = -1;
        cur_active = 1'b0;
        cur_write = 1'b0;
        cur_addr = 6'h00;
        cur_data = 8'h00;
        outputs_valid = 1'b0;
        dbo_known = 1'b0;
        reset_checked = 1'b0;
        clk_phi = 1'b0;
        ras = 1'b1;
        aec = 1'b1;
        ce = 1'b1;
        rw = 1'b1;
        adi = 6'h00;
        dbi = 8'h00;
        phi_phase_start_dav = 1'b0;
        phi_phase_start_dav_plus_1 = 1'b0;
        status = '0;
        wait (rst == 1'b0);
        for (int a = 0; a <= 'h2e; a++) begin
            run_period(1'b1, 1'b1, 6'(a), 8'($random(seed)));
        end
        outputs_valid = 1'b1;
        for (int a = 0; a < 64; a++) begin
            run_period(1'b1, 1'b0, 6'(a), 8'h00);
        end
        for (int n = 0; n < num_random; n++) begin
            r = $random(seed);
            run_period(1'b1, r[8], r[5:0], r[23:16]);
        end
        // lets the last pulses drop before the summary
        run_period(1'b0, 1'b0, 6'h00, 8'h00);
        $display("accesses %0d, errors %0d, assertion failures %0d", access_count, err_count,
                 dut_i.assert_i.fail_count);
        if (err_count == 0 && dut_i.assert_i.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired at %0t before all accesses finished", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* vic_regs_pkg.sv */
package vic_regs_pkg;

    // the register map has room for exactly eight sprites
    localparam int num_sprites = 8;

    typedef logic [3:0] color_t;

    typedef enum logic [5:0] {
        reg_sprite_x_0     = 6'h00,
        reg_sprite_y_0     = 6'h01,
        reg_sprite_x_1     = 6'h02,
        reg_sprite_y_1     = 6'h03,
        reg_sprite_x_2     = 6'h04,
        reg_sprite_y_2     = 6'h05,
        reg_sprite_x_3     = 6'h06,
        reg_sprite_y_3     = 6'h07,
        reg_sprite_x_4     = 6'h08,
        reg_sprite_y_4     = 6'h09,
        reg_sprite_x_5     = 6'h0a,
        reg_sprite_y_5     = 6'h0b,
        reg_sprite_x_6     = 6'h0c,
        reg_sprite_y_6     = 6'h0d,
        reg_sprite_x_7     = 6'h0e,
        reg_sprite_y_7     = 6'h0f,
        reg_sprite_x_msb   = 6'h10,
        reg_screen_ctrl_1  = 6'h11,
        reg_raster         = 6'h12,
        reg_lpx            = 6'h13,
        reg_lpy            = 6'h14,
        reg_sprite_en      = 6'h15,
        reg_screen_ctrl_2  = 6'h16,
        reg_sprite_ye      = 6'h17,
        reg_mem_setup      = 6'h18,
        reg_irq_status     = 6'h19,
        reg_irq_ctrl       = 6'h1a,
        reg_sprite_pri     = 6'h1b,
        reg_sprite_mmc     = 6'h1c,
        reg_sprite_xe      = 6'h1d,
        reg_sprite_m2m     = 6'h1e,
        reg_sprite_m2d     = 6'h1f,
        reg_border_color   = 6'h20,
        reg_bg_color_0     = 6'h21,
        reg_bg_color_1     = 6'h22,
        reg_bg_color_2     = 6'h23,
        reg_bg_color_3     = 6'h24,
        reg_sprite_mc_0    = 6'h25,
        reg_sprite_mc_1    = 6'h26,
        reg_sprite_color_0 = 6'h27,
        reg_sprite_color_1 = 6'h28,
        reg_sprite_color_2 = 6'h29,
        reg_sprite_color_3 = 6'h2a,
        reg_sprite_color_4 = 6'h2b,
        reg_sprite_color_5 = 6'h2c,
        reg_sprite_color_6 = 6'h2d,
        reg_sprite_color_7 = 6'h2e,
        reg_last           = 6'h3f
    } reg_addr_e;

    typedef enum logic [1:0] {
        idle,
        latched,
        read_served
    } bus_state_e;

    // qualified cpu access with one strobe per phase event
    typedef struct packed {
        logic       wr;
        logic       rd;
        logic       rd_dav;
        logic       end_access;
        logic       clr_pulses;
        reg_addr_e  addr;
        logic [7:0] data;
    } bus_req_t;

    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        color_t     col;
    } sprite_t;

    typedef struct packed {
        logic [2:0] yscroll;
        logic       rsel;
        logic       den;
        logic       bmm;
        logic       ecm;
        logic [2:0] xscroll;
        logic       csel;
        logic       mcm;
        logic       res;
    } screen_ctrl_t;

    typedef struct packed {
        logic [2:0] cb;
        logic [3:0] vm;
    } mem_setup_t;

    typedef struct packed {
        color_t ec;
        color_t b0c;
        color_t b1c;
        color_t b2c;
        color_t b3c;
        color_t mc0;
        color_t mc1;
    } colors_t;

    typedef struct packed {
        logic [7:0] en;
        logic [7:0] xe;
        logic [7:0] ye;
        logic [7:0] pri;
        logic [7:0] mmc;
    } sprite_masks_t;

    // msb first so the struct lines up with data bits 3:0 of 0x19 and 0x1a
    typedef struct packed {
        logic lp;
        logic mmc;
        logic mbc;
        logic rst;
    } irq_bits_t;

    typedef struct packed {
        logic [8:0] raster_line;
        logic [7:0] lpx;
        logic [7:0] lpy;
        logic       irq;
        irq_bits_t  irq_status;
        logic [7:0] sprite_m2m;
        logic [7:0] sprite_m2d;
    } vic_status_t;

endpackage

/* vic_sprite_slot.sv */
`timescale 1ns/1ps

module vic_sprite_slot
    import vic_regs_pkg::*;
#(
    parameter int index = 0
) (
    input  logic     clk_dot4x,
    input  bus_req_t bus_req,
    output sprite_t  sprite
);

    // x and y pairs sit at the bottom of the map and colors start at 0x27
    localparam logic [5:0] x_addr   = 6'(2 * index);
    localparam logic [5:0] y_addr   = 6'(2 * index + 1);
    localparam logic [5:0] col_addr = 6'(reg_sprite_color_0) + 6'(index);

    always_ff @(posedge clk_dot4x) begin
        if (bus_req.wr) begin
            if (bus_req.addr == x_addr) begin
                sprite.x[7:0] <= bus_req.data;
            end
            if (bus_req.addr == y_addr) begin
                sprite.y <= bus_req.data;
            end
            // x bit 8 of all sprites shares one register
            if (bus_req.addr == reg_sprite_x_msb) begin
                sprite.x[8] <= bus_req.data[index];
            end
            if (bus_req.addr == col_addr) begin
                sprite.col <= bus_req.data[3:0];
            end
        end
    end

endmodule
